//--- files.f
hw/memSysPkg.sv
hw/memBankIf.sv
hw/bankTimer.sv
hw/fillCounter.sv
hw/cacheArray.sv
hw/bankedMem.sv
hw/cacheCtrl.sv
hw/memSystem.sv
test/tbMemSystem.sv

//--- Makefile
TOP = tbMemSystem

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- test/tbMemSystem.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemSystem;

    localparam int SEED           = 87360;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int HIT_CYCLES     = 2;
    localparam int MISS_MIN       = 2 + 4 + 2;  // Compare, four issues, read latency

    logic        clk;
    logic        rst;
    logic [15:0] Addr;
    logic [15:0] DataIn;
    logic        Rd;
    logic        Wr;
    logic [15:0] DataOut;
    logic        Done;
    logic        Stall;
    logic        CacheHit;

    // Request table with one entry per row in each queue
    string       rowName  [$];
    bit          rowWrite [$];
    logic [15:0] rowAddr  [$];
    logic [15:0] rowData  [$];

    logic [15:0] shadowMem  [32768];  // Indexed by word address
    logic [4:0]  tagModel   [256];
    bit          validModel [256];

    int mismatches;
    int timeouts;

    memSystem UUT (
        .clk      (clk),
        .rst      (rst),
        .Addr     (Addr),
        .DataIn   (DataIn),
        .Rd       (Rd),
        .Wr       (Wr),
        .DataOut  (DataOut),
        .Done     (Done),
        .Stall    (Stall),
        .CacheHit (CacheHit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic addRow(input string name, input bit isWrite, input logic [15:0] addr);
        rowName.push_back(name);
        rowWrite.push_back(isWrite);
        rowAddr.push_back(addr);
        rowData.push_back(isWrite ? 16'($urandom()) : 16'h0000);
    endtask

    task automatic reportMismatch(input string name, input string what,
                                  input logic [15:0] expected, input logic [15:0] actual);
        $display("mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
        mismatches++;
    endtask

    task automatic buildTable();
        addRow("wrA0", 1'b1, 16'h0010);     // Full line at index 2
        addRow("wrA1", 1'b1, 16'h0012);
        addRow("wrA2", 1'b1, 16'h0014);
        addRow("wrA3", 1'b1, 16'h0016);
        addRow("wrB0", 1'b1, 16'h0020);
        addRow("wrB2", 1'b1, 16'h0024);
        addRow("rdA1", 1'b0, 16'h0012);     // First reads miss
        addRow("rdB0", 1'b0, 16'h0020);
        addRow("rdA3", 1'b0, 16'h0016);
        addRow("rdA0", 1'b0, 16'h0010);
        addRow("rdB2", 1'b0, 16'h0024);
        addRow("wrA2hit", 1'b1, 16'h0014);  // Write hit updates cached word
        addRow("rdA2", 1'b0, 16'h0014);
        // Evict line 2 so the written word comes back from memory
        addRow("wrG", 1'b1, 16'h0810);
        addRow("rdG", 1'b0, 16'h0810);
        addRow("rdA2mem", 1'b0, 16'h0014);
        addRow("wrD", 1'b1, 16'h0030);      // No allocate on write miss
        addRow("rdD", 1'b0, 16'h0030);
        // Same index 8 with tags 0 and 1
        addRow("wrE", 1'b1, 16'h0040);
        addRow("wrF", 1'b1, 16'h0840);
        addRow("rdE", 1'b0, 16'h0040);
        addRow("rdF", 1'b0, 16'h0840);
        addRow("rdE2", 1'b0, 16'h0040);
        addRow("wrF2", 1'b1, 16'h0840);
        addRow("rdF2", 1'b0, 16'h0840);
        addRow("rdE3", 1'b0, 16'h0040);
        addRow("wrBank0a", 1'b1, 16'h0100); // Back to back on bank 0
        addRow("wrBank0b", 1'b1, 16'h0108);
        addRow("wrBank0c", 1'b1, 16'h0100);
        addRow("wrBank1", 1'b1, 16'h0102);
        addRow("wrBank2", 1'b1, 16'h0104);
        addRow("wrBank3", 1'b1, 16'h0106);
        addRow("rdBank0a", 1'b0, 16'h0100);
        addRow("rdBank1", 1'b0, 16'h0102);
        addRow("rdBank2", 1'b0, 16'h0104);
        addRow("rdBank3", 1'b0, 16'h0106);
        addRow("rdBank0b", 1'b0, 16'h0108);
    endtask

    // Counts rising edges until Done shows up while Stall holds
    task automatic waitDone(input string name, output int cycles, output bit gotDone);
        gotDone = 1'b0;
        cycles  = 0;
        while (!gotDone && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (Done) begin
                gotDone = 1'b1;
            end else begin
                assert (Stall === 1'b1) else reportMismatch(name, "Stall", 16'h1, Stall);
            end
        end
    endtask

    task automatic checkRow(input int r, input int cycles);
        logic [7:0]  idx;
        logic [4:0]  tg;
        logic [15:0] expData;
        bit          expHit;
        idx = rowAddr[r][10:3];
        tg  = rowAddr[r][15:11];
        if (rowWrite[r]) begin
            assert (CacheHit === 1'b0) else reportMismatch(rowName[r], "CacheHit", 16'h0, CacheHit);
            shadowMem[rowAddr[r][15:1]] = rowData[r];  // Write-through always reaches memory
        end else begin
            expHit  = validModel[idx] && (tagModel[idx] == tg);
            expData = shadowMem[rowAddr[r][15:1]];
            assert (DataOut === expData) else reportMismatch(rowName[r], "DataOut", expData, DataOut);
            assert (CacheHit === expHit) else reportMismatch(rowName[r], "CacheHit", expHit, CacheHit);
            if (expHit) begin
                assert (cycles == HIT_CYCLES) else begin
                    $display("mismatch %s latency: expected %0d, actual %0d",
                             rowName[r], HIT_CYCLES, cycles);
                    mismatches++;
                end
            end else begin
                assert (cycles >= MISS_MIN) else begin
                    $display("mismatch %s latency: expected at least %0d, actual %0d",
                             rowName[r], MISS_MIN, cycles);
                    mismatches++;
                end
                validModel[idx] = 1'b1;  // Miss brings in the whole line
                tagModel[idx]   = tg;
            end
        end
    endtask

    initial begin
        int cycles;
        bit gotDone;
        rst        = 1'b1;
        Addr       = 16'h0000;
        DataIn     = 16'h0000;
        Rd         = 1'b0;
        Wr         = 1'b0;
        mismatches = 0;
        timeouts   = 0;
        void'($urandom(SEED));
        buildTable();

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (Stall === 1'b0) else reportMismatch("reset", "Stall", 16'h0, Stall);
        assert (Done === 1'b0) else reportMismatch("reset", "Done", 16'h0, Done);
        assert (CacheHit === 1'b0) else reportMismatch("reset", "CacheHit", 16'h0, CacheHit);

        for (int r = 0; r < rowName.size(); r++) begin
            @(posedge clk);
            Addr   <= rowAddr[r];
            DataIn <= rowData[r];
            Rd     <= !rowWrite[r];
            Wr     <= rowWrite[r];
            waitDone(rowName[r], cycles, gotDone);
            if (!gotDone) begin
                $display("timeout: row %s got no Done within %0d cycles",
                         rowName[r], TIMEOUT_CYCLES);
                timeouts++;
                break;
            end
            checkRow(r, cycles);
            @(posedge clk);
            Rd <= 1'b0;  // Drop the request for one cycle
            Wr <= 1'b0;
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/memSystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSystem (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] Addr,
    input  logic [15:0] DataIn,
    input  logic        Rd,
    input  logic        Wr,
    output logic [15:0] DataOut,
    output logic        Done,
    output logic        Stall,
    output logic        CacheHit
);
    import memSysPkg::*;

    // Cache port
    logic [$clog2(CACHE_LINES)-1:0]    index;
    logic [4:0]                        tag;
    logic [$clog2(WORDS_PER_LINE)-1:0] wordSel;
    logic                              comp;
    logic                              write;
    logic                              validIn;
    logic [15:0]                       cacheDataIn;
    logic                              hit;
    logic                              valid;

    // Line fill bookkeeping
    logic                              start;
    logic                              issue;
    logic [$clog2(WORDS_PER_LINE)-1:0] issueWord;
    logic [$clog2(WORDS_PER_LINE)-1:0] returnWord;
    logic                              allIssued;
    logic                              allReturned;

    memBankIf memBus ();

    cacheCtrl ctrl (
        .clk         (clk),
        .rst         (rst),
        .Addr        (Addr),
        .DataIn      (DataIn),
        .Rd          (Rd),
        .Wr          (Wr),
        .Done        (Done),
        .Stall       (Stall),
        .CacheHit    (CacheHit),
        .mem         (memBus.ctrl),
        .index       (index),
        .tag         (tag),
        .wordSel     (wordSel),
        .comp        (comp),
        .write       (write),
        .validIn     (validIn),
        .dataIn      (cacheDataIn),
        .hit         (hit),
        .valid       (valid),
        .start       (start),
        .issue       (issue),
        .issueWord   (issueWord),
        .returnWord  (returnWord),
        .allIssued   (allIssued),
        .allReturned (allReturned)
    );

    fillCounter fill (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .issue       (issue),
        .rdValid     (memBus.rdValid),
        .issueWord   (issueWord),
        .returnWord  (returnWord),
        .allIssued   (allIssued),
        .allReturned (allReturned)
    );

    cacheArray array (
        .clk     (clk),
        .rst     (rst),
        .index   (index),
        .tag     (tag),
        .wordSel (wordSel),
        .comp    (comp),
        .write   (write),
        .validIn (validIn),
        .dataIn  (cacheDataIn),
        .dataOut (DataOut),
        .hit     (hit),
        .valid   (valid)
    );

    bankedMem banks (
        .clk (clk),
        .rst (rst),
        .bus (memBus.mem)
    );

endmodule

`default_nettype wire

//--- hw/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
    input  logic                                         clk,
    input  logic                                         rst,
    input  memSysPkg::cacheAddrT                         Addr,
    input  logic [15:0]                                  DataIn,
    input  logic                                         Rd,
    input  logic                                         Wr,
    output logic                                         Done,
    output logic                                         Stall,
    output logic                                         CacheHit,
    memBankIf.ctrl                                       mem,
    output logic [$clog2(memSysPkg::CACHE_LINES)-1:0]    index,
    output logic [4:0]                                   tag,
    output logic [$clog2(memSysPkg::WORDS_PER_LINE)-1:0] wordSel,
    output logic                                         comp,
    output logic                                         write,
    output logic                                         validIn,
    output logic [15:0]                                  dataIn,
    input  logic                                         hit,
    input  logic                                         valid,
    output logic                                         start,
    output logic                                         issue,
    input  logic [$clog2(memSysPkg::WORDS_PER_LINE)-1:0] issueWord,
    input  logic [$clog2(memSysPkg::WORDS_PER_LINE)-1:0] returnWord,
    input  logic                                         allIssued,
    input  logic                                         allReturned
);
    import memSysPkg::*;

    ctrlStateT                         state;
    ctrlStateT                         nextState;
    cacheAddrT                         memAddr;
    logic [$clog2(WORDS_PER_LINE)-1:0] targetBank;
    logic                              hitValid;
    logic                              bankBusy;
    logic                              fillWrite;
    logic                              missed;    // Current read already took a miss

    assign hitValid  = hit && valid;
    assign fillWrite = mem.rdValid && (state == ReadMem || state == WaitData);
    assign Stall     = (state != Idle);

    // Fill reads walk the banks, everything else uses the request word
    always_comb begin
        memAddr = Addr;
        memAddr.memView.byteSel = 1'b0;
        if (state == ReadMem) begin
            memAddr.memView.bank = issueWord;
        end
    end

    assign targetBank = memAddr.memView.bank;
    assign bankBusy   = mem.busy[targetBank];

    assign mem.addr   = memAddr;
    assign mem.wrData = DataIn;
    assign mem.wr     = (state == WriteMem) && !bankBusy;
    assign mem.rd     = (state == ReadMem) && !allIssued && !bankBusy;
    assign issue      = mem.rd;
    assign start      = (state == CompareTag) && Rd && !hitValid;

    assign index   = Addr.cacheView.index;
    assign tag     = Addr.cacheView.tag;
    assign wordSel = fillWrite ? returnWord : Addr.cacheView.offset[2:1];
    assign comp    = (state == CompareTag);
    assign write   = fillWrite || (comp && Wr);
    assign validIn = fillWrite && (&returnWord);  // Line turns valid with its last word
    assign dataIn  = fillWrite ? mem.rdData : DataIn;

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                // Requester still holds the old request while Done is up
                if ((Rd || Wr) && !Done) begin
                    nextState = CompareTag;
                end
            end
            CompareTag: begin
                if (Wr) begin
                    nextState = WriteMem;
                end else if (hitValid) begin
                    nextState = Idle;
                end else begin
                    nextState = ReadMem;
                end
            end
            WriteMem: begin
                if (!bankBusy) begin
                    nextState = Idle;
                end
            end
            ReadMem: begin
                if (allIssued) begin
                    nextState = WaitData;
                end
            end
            WaitData: begin
                if (allReturned) begin
                    nextState = Allocate;
                end
            end
            Allocate:   nextState = CompareTag;  // Recompare now hits
            default:    nextState = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= Idle;
            Done     <= 1'b0;
            CacheHit <= 1'b0;
            missed   <= 1'b0;
        end else begin
            state    <= nextState;
            Done     <= (comp && Rd && hitValid) || mem.wr;
            CacheHit <= comp && Rd && hitValid && !missed;
            if (start) begin
                missed <= 1'b1;
            end else if (state == Idle) begin
                missed <= 1'b0;
            end
        end
    end

    // Done only ever lands on the return to Idle
    assert property (@(posedge clk) disable iff (rst) Done |-> (state == Idle) && !Stall);

    assert property (@(posedge clk) disable iff (rst) !(mem.wr && mem.rd));

endmodule

`default_nettype wire

//--- hw/bankedMem.sv
`timescale 1ns/1ps
`default_nettype none

module bankedMem (
    input  logic   clk,
    input  logic   rst,
    memBankIf.mem  bus
);
    import memSysPkg::*;

    cacheAddrT                   addrView;
    logic [WORDS_PER_LINE-1:0]   access;
    logic [15:0]                 bankRd    [WORDS_PER_LINE];
    logic [MEM_READ_LATENCY-1:0] validPipe;
    logic [15:0]                 dataPipe  [MEM_READ_LATENCY];

    assign addrView = bus.addr;

    for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : gBank
        logic [15:0] words [2**13];  // One word per row

        assign access[b] = (bus.wr || bus.rd) && (addrView.memView.bank == b);
        assign bankRd[b] = words[addrView.memView.row];

        always_ff @(posedge clk) begin
            if (bus.wr && access[b]) begin
                words[addrView.memView.row] <= bus.wrData;
            end
        end

        bankTimer timer (
            .clk    (clk),
            .rst    (rst),
            .access (access[b]),
            .busy   (bus.busy[b])
        );

        // Busy window opens the cycle after the access
        assert property (@(posedge clk) disable iff (rst)
            access[b] |=> bus.busy[b] ##(BANK_BUSY_CYCLES - 1) bus.busy[b] ##1 !bus.busy[b]);
    end

    // Fixed latency read pipe, keeps overlapping reads in order
    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[MEM_READ_LATENCY-2:0], bus.rd};
        end
    end

    always_ff @(posedge clk) begin
        dataPipe[0] <= bankRd[addrView.memView.bank];
        for (int s = 1; s < MEM_READ_LATENCY; s++) begin
            dataPipe[s] <= dataPipe[s-1];
        end
    end

    assign bus.rdValid = validPipe[MEM_READ_LATENCY-1];
    assign bus.rdData  = dataPipe[MEM_READ_LATENCY-1];

    assert property (@(posedge clk) disable iff (rst)
        (bus.rd || bus.wr) |-> !bus.busy[addrView.memView.bank]);

endmodule

`default_nettype wire

//--- hw/cacheArray.sv
`timescale 1ns/1ps
`default_nettype none

module cacheArray (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic [$clog2(memSysPkg::CACHE_LINES)-1:0]    index,
    input  logic [4:0]                                   tag,
    input  logic [$clog2(memSysPkg::WORDS_PER_LINE)-1:0] wordSel,
    input  logic                                         comp,
    input  logic                                         write,
    input  logic                                         validIn,
    input  logic [15:0]                                  dataIn,
    output logic [15:0]                                  dataOut,
    output logic                                         hit,
    output logic                                         valid
);
    import memSysPkg::*;

    logic [4:0]       tagMem  [CACHE_LINES];
    logic [15:0]      dataMem [CACHE_LINES][WORDS_PER_LINE];
    logic [CACHE_LINES-1:0] validBits;
    logic             allocWrite;
    logic             wordWrite;

    // Allocate writes the word and retags the line
    assign allocWrite = write && !comp;

    // Compare writes only touch a line that is really present
    assign wordWrite = allocWrite || (write && hit && valid);

    assign hit     = (tagMem[index] == tag);  // Raw tag match
    assign valid   = validBits[index];
    assign dataOut = dataMem[index][wordSel];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (allocWrite) begin
            validBits[index] <= validIn;
        end
    end

    always_ff @(posedge clk) begin
        if (wordWrite) begin
            dataMem[index][wordSel] <= dataIn;
        end
        if (allocWrite) begin
            tagMem[index] <= tag;
        end
    end

endmodule

`default_nettype wire

//--- hw/fillCounter.sv
`timescale 1ns/1ps
`default_nettype none

module fillCounter (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         start,
    input  logic                                         issue,
    input  logic                                         rdValid,
    output logic [$clog2(memSysPkg::WORDS_PER_LINE)-1:0] issueWord,
    output logic [$clog2(memSysPkg::WORDS_PER_LINE)-1:0] returnWord,
    output logic                                         allIssued,
    output logic                                         allReturned
);
    import memSysPkg::*;

    // One extra bit so a full line reads as the top bit set
    logic [$clog2(WORDS_PER_LINE):0] issueCnt;
    logic [$clog2(WORDS_PER_LINE):0] returnCnt;

    always_ff @(posedge clk) begin
        if (rst || start) begin
            issueCnt  <= '0;
            returnCnt <= '0;
        end else begin
            if (issue) begin
                issueCnt <= issueCnt + 1'b1;
            end
            if (rdValid) begin
                returnCnt <= returnCnt + 1'b1;
            end
        end
    end

    assign issueWord   = issueCnt[$clog2(WORDS_PER_LINE)-1:0];
    assign returnWord  = returnCnt[$clog2(WORDS_PER_LINE)-1:0];  // Word arriving this cycle
    assign allIssued   = issueCnt[$clog2(WORDS_PER_LINE)];
    assign allReturned = returnCnt[$clog2(WORDS_PER_LINE)];

    assert property (@(posedge clk) disable iff (rst) returnCnt <= issueCnt);

    // Each fill read comes back after the fixed bank latency
    assert property (@(posedge clk) disable iff (rst) issue |-> ##MEM_READ_LATENCY rdValid);

endmodule

`default_nettype wire

//--- hw/bankTimer.sv
`timescale 1ns/1ps
`default_nettype none

module bankTimer (
    input  logic clk,
    input  logic rst,
    input  logic access,
    output logic busy
);
    import memSysPkg::*;

    logic [$clog2(BANK_BUSY_CYCLES+1)-1:0] count;  // Cycles left in the busy window

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (access) begin
            count <= BANK_BUSY_CYCLES[$clog2(BANK_BUSY_CYCLES+1)-1:0];
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

endmodule

`default_nettype wire

//--- hw/memBankIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memBankIf;

    logic [15:0] addr;     // Word aligned
    logic [15:0] wrData;
    logic        wr;       // Single cycle strobe
    logic        rd;       // Single cycle strobe
    logic [15:0] rdData;
    logic        rdValid;
    logic [3:0]  busy;     // One bit per bank

    // Controller side
    modport ctrl (output addr, wrData, wr, rd, input rdData, rdValid, busy);

    // Memory side
    modport mem (input addr, wrData, wr, rd, output rdData, rdValid, busy);

endinterface

`default_nettype wire

//--- hw/memSysPkg.sv
`default_nettype none

package memSysPkg;

    // One line holds one word from each bank
    localparam int WORDS_PER_LINE   = 4;
    localparam int CACHE_LINES      = 256;
    localparam int BANK_BUSY_CYCLES = 4;  // Bank recovery after any access
    localparam int MEM_READ_LATENCY = 2;  // Cycles from rd to rdValid

    // Same byte address, split for the cache or for the banks
    typedef union packed {
        struct packed {
            logic [4:0] tag;
            logic [7:0] index;
            logic [2:0] offset;
        } cacheView;
        struct packed {
            logic [12:0] row;
            logic [1:0]  bank;
            logic        byteSel;
        } memView;
    } cacheAddrT;

    typedef enum logic [2:0] {
        Idle,
        CompareTag,
        WriteMem,
        ReadMem,
        WaitData,
        Allocate
    } ctrlStateT;

endpackage

`default_nettype wire
